//--- Makefile
TOP = tb_processor

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): sim.f source/*.sv verif/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

//--- sim.f
source/proc_pkg.sv
source/alu.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_writeback.sv
source/processor.sv
verif/tb_processor.sv

//--- source/alu.sv
/*
 * Arithmetic and logic unit
 * Add, subtract, bitwise and/or, logical left shift and arithmetic
 * right shift by shamt, plus signed compare flags for the branches
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  proc_pkg::word_t   operand_a,
    input  proc_pkg::word_t   operand_b,
    input  proc_pkg::alu_op_e op,
    input  logic [4:0]        shamt,
    output proc_pkg::word_t   result,
    output logic              not_equal,
    output logic              less_than
);
    import proc_pkg::*;

    always_comb begin
        case (op)
            alu_add: begin
                result = operand_a + operand_b;
            end
            alu_sub: begin
                result = operand_a - operand_b;
            end
            alu_and: begin
                result = operand_a & operand_b;
            end
            alu_or: begin
                result = operand_a | operand_b;
            end
            alu_sll: begin
                result = operand_a << shamt;
            end
            alu_sra: begin
                result = word_t'($signed(operand_a) >>> shamt);
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Flags compare the operands directly so a subtract overflow cannot flip them
    assign not_equal = (operand_a != operand_b);
    assign less_than = ($signed(operand_a) < $signed(operand_b));

endmodule

`default_nettype wire

//--- source/decode_stage.sv
/*
 * Decode stage
 * Drives the register-file read addresses, detects a load-use hazard
 * against the load in execute, and fills the decode/execute register,
 * inserting a bubble on stall or branch flush
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                clock,
    input  logic                reset,
    input  proc_pkg::if_id_t    if_id,
    input  logic                redirect_valid,
    input  proc_pkg::word_t     data_read_a,
    input  proc_pkg::word_t     data_read_b,
    output proc_pkg::reg_addr_t read_reg_a,
    output proc_pkg::reg_addr_t read_reg_b,
    output logic                stall,
    output proc_pkg::id_ex_t    id_ex
);
    import proc_pkg::*;

    opcode_e   opcode;
    reg_addr_t load_rd;
    logic      load_in_ex;
    logic      needs_a;
    logic      needs_b;

    assign opcode     = opcode_of(if_id.insn);
    assign read_reg_a = rs_of(if_id.insn);
    assign read_reg_b = src_b_of(if_id.insn);

    // Operands that must be valid when this instruction enters execute
    always_comb begin
        needs_a = 1'b0;
        needs_b = 1'b0;
        case (opcode)
            op_alu, op_bne, op_blt: begin
                needs_a = 1'b1;
                needs_b = 1'b1;
            end
            // sw store data is picked up later by the memory-stage bypass
            op_addi, op_lw, op_sw: needs_a = 1'b1;
            op_jr: needs_b = 1'b1;
            default: begin
                needs_a = 1'b0;
                needs_b = 1'b0;
            end
        endcase
    end

    assign load_rd    = rd_of(id_ex.insn);
    assign load_in_ex = (opcode_of(id_ex.insn) == op_lw) && (load_rd != '0);

    assign stall = load_in_ex &&
                   ((needs_a && (read_reg_a == load_rd)) ||
                    (needs_b && (read_reg_b == load_rd)));

    always_ff @(posedge clock) begin
        id_ex.pc <= if_id.pc;
        id_ex.a  <= data_read_a;
        id_ex.b  <= data_read_b;
        if (reset) begin
            id_ex.insn <= nop_word;
        end else if (stall || redirect_valid) begin
            // Bubble for the load-use wait or the flushed slot
            id_ex.insn <= nop_word;
        end else begin
            id_ex.insn <= if_id.insn;
        end
    end

    // The bubble clears the hazard, so one wait cycle is always enough
    assert property (@(posedge clock) disable iff (reset)
        stall |=> !stall);

endmodule

`default_nettype wire

//--- source/execute_stage.sv
/*
 * Execute stage
 * Bypasses both operands from the memory and writeback stages, selects
 * the immediate, runs the ALU, resolves branches and jumps into a
 * redirect, and loads the execute/memory register
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  proc_pkg::id_ex_t     id_ex,
    input  proc_pkg::reg_write_t reg_write,
    output logic                 redirect_valid,
    output proc_pkg::word_t      redirect_pc,
    output proc_pkg::ex_mem_t    ex_mem
);
    import proc_pkg::*;

    opcode_e opcode;
    alu_op_e alu_op;
    word_t   operand_a;
    word_t   operand_b;
    word_t   immediate;
    word_t   alu_b;
    word_t   alu_result;
    word_t   result;
    logic    uses_imm;
    logic    not_equal;
    logic    less_than;

    // Youngest producer first, then writeback, then the register file value
    function automatic word_t bypass(
        input reg_addr_t  src,
        input word_t      reg_value,
        input ex_mem_t    mem_stage,
        input reg_write_t wb_stage
    );
        if (writes_reg(mem_stage.insn) && (dest_of(mem_stage.insn) == src)) begin
            return mem_stage.o;
        end
        if (wb_stage.enable && (wb_stage.addr == src) && (src != '0)) begin
            return wb_stage.data;
        end
        return reg_value;
    endfunction

    assign opcode    = opcode_of(id_ex.insn);
    assign immediate = sext_imm(id_ex.insn);
    assign operand_a = bypass(rs_of(id_ex.insn), id_ex.a, ex_mem, reg_write);
    assign operand_b = bypass(src_b_of(id_ex.insn), id_ex.b, ex_mem, reg_write);

    assign uses_imm = (opcode == op_addi) || (opcode == op_lw) || (opcode == op_sw);
    assign alu_b    = uses_imm ? immediate : operand_b;

    always_comb begin
        case (opcode)
            op_addi, op_lw, op_sw: alu_op = alu_add;
            op_bne, op_blt: alu_op = alu_sub;
            default: alu_op = alu_op_e'(id_ex.insn[6:2]);
        endcase
    end

    alu u_alu (
        .operand_a (operand_a),
        .operand_b (alu_b),
        .op        (alu_op),
        .shamt     (id_ex.insn[11:7]),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // ALU sees rs on a and rd on b, so blt is taken when rs > rd
    always_comb begin
        redirect_valid = 1'b0;
        redirect_pc    = id_ex.pc + immediate;
        case (opcode)
            op_bne: redirect_valid = not_equal;
            op_blt: redirect_valid = not_equal && !less_than;
            op_j, op_jal: begin
                redirect_valid = 1'b1;
                redirect_pc    = sext_target(id_ex.insn);
            end
            op_jr: begin
                redirect_valid = 1'b1;
                redirect_pc    = operand_b;
            end
            default: redirect_valid = 1'b0;
        endcase
    end

    // jal carries its return address down the pipe as the result
    assign result = (opcode == op_jal) ? id_ex.pc : alu_result;

    always_ff @(posedge clock) begin
        ex_mem.o <= result;
        ex_mem.b <= operand_b;
        if (reset) begin
            ex_mem.insn <= nop_word;
        end else begin
            ex_mem.insn <= id_ex.insn;
        end
    end

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
/*
 * Fetch stage
 * Holds the program counter, picks the next PC from redirect, stall or
 * increment, and loads the fetch/decode register, which is flushed on
 * a redirect and held on a stall
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic             clock,
    input  logic             reset,
    input  logic             stall,
    input  logic             redirect_valid,
    input  proc_pkg::word_t  redirect_pc,
    input  proc_pkg::word_t  q_imem,
    output proc_pkg::word_t  address_imem,
    output proc_pkg::if_id_t if_id
);
    import proc_pkg::*;

    word_t pc;
    word_t pc_plus_one;

    assign pc_plus_one  = pc + 32'd1;
    assign address_imem = pc;

    // Redirect wins over stall
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc_plus_one;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            if_id.pc <= pc_plus_one;
        end
        if (reset || redirect_valid) begin
            // Word fetched behind a taken branch never issues
            if_id.insn <= nop_word;
        end else if (!stall) begin
            if_id.insn <= q_imem;
        end
    end

    // Decode stall must freeze the PC unless execute redirects
    assert property (@(posedge clock) disable iff (reset)
        stall && !redirect_valid |=> $stable(pc));

endmodule

`default_nettype wire

//--- source/memory_writeback.sv
/*
 * Memory and writeback stages
 * Issues the data-memory request with the store-data bypass from
 * writeback, loads the memory/writeback register and derives the
 * register-file write enable, destination and data
 */
`timescale 1ns/1ps
`default_nettype none

module memory_writeback (
    input  logic                 clock,
    input  logic                 reset,
    input  proc_pkg::ex_mem_t    ex_mem,
    input  proc_pkg::word_t      q_dmem,
    output proc_pkg::dmem_req_t  dmem_req,
    output proc_pkg::reg_write_t reg_write
);
    import proc_pkg::*;

    mem_wb_t mem_wb;
    logic    store_bypass;

    // A load right ahead of the store has its data only now
    assign store_bypass = reg_write.enable && (reg_write.addr == rd_of(ex_mem.insn));

    assign dmem_req.address = ex_mem.o;
    assign dmem_req.data    = store_bypass ? reg_write.data : ex_mem.b;
    assign dmem_req.write   = (opcode_of(ex_mem.insn) == op_sw);

    always_ff @(posedge clock) begin
        mem_wb.o <= ex_mem.o;
        mem_wb.d <= q_dmem;
        if (reset) begin
            mem_wb.insn <= nop_word;
        end else begin
            mem_wb.insn <= ex_mem.insn;
        end
    end

    assign reg_write.enable = writes_reg(mem_wb.insn);
    assign reg_write.addr   = dest_of(mem_wb.insn);
    assign reg_write.data   = (opcode_of(mem_wb.insn) == op_lw) ? mem_wb.d : mem_wb.o;

    // r0 stays zero, and the bypass paths count on it
    assert property (@(posedge clock) disable iff (reset)
        reg_write.enable |-> (reg_write.addr != '0));

endmodule

`default_nettype wire

//--- source/proc_pkg.sv
/*
 * Processor core package
 * Word and register-number types, opcode and ALU operation encodings,
 * the layouts of the four pipeline registers, the register-file write
 * and data-memory request bundles, and instruction field helpers
 */
`default_nettype none

package proc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcode in bits 31..27
    typedef enum logic [4:0] {
        op_alu  = 5'b00000,
        op_j    = 5'b00001,
        op_bne  = 5'b00010,
        op_jal  = 5'b00011,
        op_jr   = 5'b00100,
        op_addi = 5'b00101,
        op_blt  = 5'b00110,
        op_sw   = 5'b00111,
        op_lw   = 5'b01000
    } opcode_e;

    // R-type function field in bits 6..2
    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    localparam reg_addr_t link_reg = 5'd31;
    localparam word_t     nop_word = 32'd0;

    typedef struct packed {
        word_t pc;
        word_t insn;
    } if_id_t;

    typedef struct packed {
        word_t pc;
        word_t a;
        word_t b;
        word_t insn;
    } id_ex_t;

    typedef struct packed {
        word_t o;
        word_t b;
        word_t insn;
    } ex_mem_t;

    typedef struct packed {
        word_t o;
        word_t d;
        word_t insn;
    } mem_wb_t;

    typedef struct packed {
        logic      enable;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

    typedef struct packed {
        word_t address;
        word_t data;
        logic  write;
    } dmem_req_t;

    function automatic opcode_e opcode_of(input word_t insn);
        return opcode_e'(insn[31:27]);
    endfunction

    function automatic reg_addr_t rd_of(input word_t insn);
        return insn[26:22];
    endfunction

    function automatic reg_addr_t rs_of(input word_t insn);
        return insn[21:17];
    endfunction

    // Second operand is rd for stores, branches and jr
    function automatic reg_addr_t src_b_of(input word_t insn);
        case (opcode_of(insn))
            op_sw, op_bne, op_blt, op_jr: return insn[26:22];
            default: return insn[16:12];
        endcase
    endfunction

    function automatic reg_addr_t dest_of(input word_t insn);
        return (opcode_of(insn) == op_jal) ? link_reg : insn[26:22];
    endfunction

    // True only when the instruction really changes a register
    function automatic logic writes_reg(input word_t insn);
        logic writer;
        case (opcode_of(insn))
            op_alu, op_addi, op_lw, op_jal: writer = 1'b1;
            default: writer = 1'b0;
        endcase
        return writer && (dest_of(insn) != '0);
    endfunction

    function automatic word_t sext_imm(input word_t insn);
        return {{15{insn[16]}}, insn[16:0]};
    endfunction

    function automatic word_t sext_target(input word_t insn);
        return {{5{insn[26]}}, insn[26:0]};
    endfunction

endpackage

`default_nettype wire

//--- source/processor.sv
/*
 * Five-stage pipelined processor core
 * Connects fetch, decode, execute and memory/writeback to the external
 * instruction memory, data memory and register-file ports
 */
`timescale 1ns/1ps
`default_nettype none

module processor (
    input  logic                 clock,
    input  logic                 reset,
    output proc_pkg::word_t      address_imem,
    input  proc_pkg::word_t      q_imem,
    output proc_pkg::dmem_req_t  dmem_req,
    input  proc_pkg::word_t      q_dmem,
    output proc_pkg::reg_addr_t  read_reg_a,
    output proc_pkg::reg_addr_t  read_reg_b,
    input  proc_pkg::word_t      data_read_a,
    input  proc_pkg::word_t      data_read_b,
    output proc_pkg::reg_write_t reg_write
);
    import proc_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    word_t   redirect_pc;
    logic    redirect_valid;
    logic    stall;

    fetch_stage u_fetch (
        .clock          (clock),
        .reset          (reset),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .q_imem         (q_imem),
        .address_imem   (address_imem),
        .if_id          (if_id)
    );

    decode_stage u_decode (
        .clock          (clock),
        .reset          (reset),
        .if_id          (if_id),
        .redirect_valid (redirect_valid),
        .data_read_a    (data_read_a),
        .data_read_b    (data_read_b),
        .read_reg_a     (read_reg_a),
        .read_reg_b     (read_reg_b),
        .stall          (stall),
        .id_ex          (id_ex)
    );

    execute_stage u_execute (
        .clock          (clock),
        .reset          (reset),
        .id_ex          (id_ex),
        .reg_write      (reg_write),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .ex_mem         (ex_mem)
    );

    memory_writeback u_memory_writeback (
        .clock     (clock),
        .reset     (reset),
        .ex_mem    (ex_mem),
        .q_dmem    (q_dmem),
        .dmem_req  (dmem_req),
        .reg_write (reg_write)
    );

endmodule

`default_nettype wire

//--- verif/processor_vectors.txt
# Columns: I <instruction hex> | R <register dec> <value hex> <name> | S <address hex> <data hex> <name>
# Program words load from address 0; expected writes and stores follow in execution order
I 28400005  # 0  addi r1, r0, 5
I 2881fffd  # 1  addi r2, r0, -3
I 00c22000  # 2  add r3, r1, r2
I 01061004  # 3  sub r4, r3, r1
I 01481008  # 4  and r5, r4, r1
I 018a400c  # 5  or r6, r5, r4
I 01cc0210  # 6  sll r7, r6, 4
I 020e0114  # 7  sra r8, r7, 2
I 2a400010  # 8  addi r9, r0, 16
I 3a120000  # 9  sw r8, 0(r9)
I 38d20001  # 10 sw r3, 1(r9)
I 42920000  # 11 lw r10, 0(r9)
I 02d41000  # 12 add r11, r10, r1
I 43000020  # 13 lw r12, 32(r0)
I 3b120002  # 14 sw r12, 2(r9)
I 3ad20003  # 15 sw r11, 3(r9)
I 10420002  # 16 bne r1, r1, 2 not taken
I 2b400001  # 17 addi r13, r0, 1
I 13420002  # 18 bne r13, r1, 2 taken to 21
I 2b800063  # 19 addi r14, r0, 99 flushed
I 38520000  # 20 sw r1, 0(r9) flushed
I 305a0002  # 21 blt r1, r13, 2 not taken
I 33420002  # 22 blt r13, r1, 2 taken to 25
I 2b80004d  # 23 addi r14, r0, 77 flushed
I 2bc00058  # 24 addi r15, r0, 88 flushed
I 30820001  # 25 blt r2, r1, 1 signed, taken to 27
I 2b800037  # 26 addi r14, r0, 55 flushed
I 1800001e  # 27 jal 30
I 2c000007  # 28 addi r16, r0, 7
I 08000022  # 29 j 34
I 2c400123  # 30 addi r17, r0, 0x123
I 27c00000  # 31 jr r31
I 2c800001  # 32 addi r18, r0, 1 flushed
I 2cc00001  # 33 addi r19, r0, 1 flushed
I 08000022  # 34 j 34 halt loop
R 1 00000005 addi_imm
R 2 fffffffd addi_negative
R 3 00000002 add_both_bypass
R 4 fffffffd sub_mem_bypass
R 5 00000005 and_chain
R 6 fffffffd or_wb_bypass
R 7 ffffffd0 sll_shift
R 8 fffffff4 sra_sign_fill
R 9 00000010 addi_base
R 10 fffffff4 lw_after_store
R 11 fffffff9 load_use_stall
R 12 d0000020 lw_filled_word
R 13 00000001 addi_after_bne
R 31 0000001c jal_link
R 17 00000123 jal_target_body
R 16 00000007 jr_return
S 00000010 fffffff4 sw_wb_bypass
S 00000011 00000002 sw_offset
S 00000012 d0000020 sw_loaded_data
S 00000013 fffffff9 sw_computed_data

//--- verif/tb_processor.sv
/*
 * Testbench for the pipelined processor core
 * Models the instruction memory, the data memory and the write-through
 * register file, loads the program and the expected register writes and
 * stores from the vectors file, and checks every write event in order
 */
`timescale 1ns/1ps
`default_nettype none

module tb_processor;
    import proc_pkg::*;

    localparam int mem_words    = 256;
    localparam int max_expected = 64;
    localparam int max_cycles   = 400;
    localparam int tail_cycles  = 8;

    logic       clock;
    logic       reset;
    word_t      address_imem;
    word_t      q_imem;
    dmem_req_t  dmem_req;
    word_t      q_dmem;
    reg_addr_t  read_reg_a;
    reg_addr_t  read_reg_b;
    word_t      data_read_a;
    word_t      data_read_b;
    reg_write_t reg_write;

    word_t imem [mem_words];
    word_t dmem [mem_words];
    word_t regs [32];

    reg_write_t expected_writes [max_expected];
    string      write_names [max_expected];
    dmem_req_t  expected_stores [max_expected];
    string      store_names [max_expected];
    int         write_count;
    int         store_count;
    int         write_index;
    int         store_index;
    int         cycle;

    processor uut (
        .clock        (clock),
        .reset        (reset),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .dmem_req     (dmem_req),
        .q_dmem       (q_dmem),
        .read_reg_a   (read_reg_a),
        .read_reg_b   (read_reg_b),
        .data_read_a  (data_read_a),
        .data_read_b  (data_read_b),
        .reg_write    (reg_write)
    );

    always #20 clock = ~clock;

    task automatic report_failure(input string text);
        $display("%s", text);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Untouched data memory returns a value built from its address
    function automatic word_t fill_word(input int index);
        return 32'hd000_0000 | word_t'(index);
    endfunction

    // Write-through read, r0 is hardwired to zero
    function automatic word_t regfile_read(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (reg_write.enable && (reg_write.addr == addr)) begin
            return reg_write.data;
        end
        return regs[addr];
    endfunction

    task automatic load_vectors;
        int                fd;
        int                code;
        int                imem_count;
        int                reg_num;
        logic              done;
        logic [8*8-1:0]    tag;
        logic [8*24-1:0]   name_bits;
        logic [8*128-1:0]  rest;
        word_t             field_a;
        word_t             field_b;
        fd = $fopen("verif/processor_vectors.txt", "r");
        assert (fd != 0) else report_failure("cannot open the vectors file");
        imem_count = 0;
        done = 1'b0;
        while (!done && !$feof(fd)) begin
            tag = '0;
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                // Comment runs to the end of the line
                code = $fgets(rest, fd);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h", field_a);
                assert (code == 1 && imem_count < mem_words)
                    else report_failure("bad program word in the vectors file");
                imem[imem_count] = field_a;
                imem_count++;
            end else if (tag == "R") begin
                code = $fscanf(fd, "%d %h %s", reg_num, field_a, name_bits);
                assert (code == 3 && write_count < max_expected)
                    else report_failure("bad register write record in the vectors file");
                expected_writes[write_count].enable = 1'b1;
                expected_writes[write_count].addr   = reg_num[4:0];
                expected_writes[write_count].data   = field_a;
                write_names[write_count] = string'(name_bits);
                write_count++;
            end else if (tag == "S") begin
                code = $fscanf(fd, "%h %h %s", field_a, field_b, name_bits);
                assert (code == 3 && store_count < max_expected)
                    else report_failure("bad store record in the vectors file");
                expected_stores[store_count].address = field_a;
                expected_stores[store_count].data    = field_b;
                expected_stores[store_count].write   = 1'b1;
                store_names[store_count] = string'(name_bits);
                store_count++;
            end else begin
                report_failure("unknown record tag in the vectors file");
            end
        end
        $fclose(fd);
    endtask

    // Combinational reads of all three models for the current cycle
    task automatic drive_models;
        q_imem      = imem[address_imem[7:0]];
        q_dmem      = dmem[dmem_req.address[7:0]];
        data_read_a = regfile_read(read_reg_a);
        data_read_b = regfile_read(read_reg_b);
    endtask

    task automatic check_events;
        assert (!$isunknown(reg_write.enable) && !$isunknown(dmem_req.write))
            else report_failure("register write enable or store strobe is unknown");
        if (reg_write.enable) begin
            assert (write_index < write_count)
                else report_failure($sformatf("unexpected register write to r%0d",
                                              reg_write.addr));
            assert ((reg_write.addr == expected_writes[write_index].addr) &&
                    (reg_write.data == expected_writes[write_index].data))
                else report_failure($sformatf("mismatch %s expected r%0d=%h actual r%0d=%h",
                                              write_names[write_index],
                                              expected_writes[write_index].addr,
                                              expected_writes[write_index].data,
                                              reg_write.addr, reg_write.data));
            regs[reg_write.addr] = reg_write.data;
            write_index++;
        end
        if (dmem_req.write) begin
            assert (store_index < store_count)
                else report_failure($sformatf("unexpected store to address %h",
                                              dmem_req.address));
            assert ((dmem_req.address == expected_stores[store_index].address) &&
                    (dmem_req.data == expected_stores[store_index].data))
                else report_failure($sformatf("mismatch %s expected [%h]=%h actual [%h]=%h",
                                              store_names[store_index],
                                              expected_stores[store_index].address,
                                              expected_stores[store_index].data,
                                              dmem_req.address, dmem_req.data));
            assert (dmem_req.address < mem_words)
                else report_failure("store address lies outside the data memory");
            dmem[dmem_req.address[7:0]] = dmem_req.data;
            store_index++;
        end
    endtask

    task automatic step_cycle;
        @(posedge clock);
        #1;
        drive_models();
        check_events();
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        q_imem      = '0;
        q_dmem      = '0;
        data_read_a = '0;
        data_read_b = '0;
        write_count = 0;
        store_count = 0;
        write_index = 0;
        store_index = 0;
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = nop_word;
            dmem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        load_vectors();

        repeat (4) begin
            @(posedge clock);
            #1;
            drive_models();
            assert (!reg_write.enable && !dmem_req.write)
                else report_failure("register write or store seen during reset");
        end
        reset = 1'b0;
        assert (address_imem == '0)
            else report_failure($sformatf("mismatch reset_pc expected %h actual %h",
                                          32'h0, address_imem));

        cycle = 0;
        while ((write_index < write_count) || (store_index < store_count)) begin
            assert (cycle < max_cycles)
                else report_failure("timeout while waiting for register writes or stores");
            step_cycle();
            cycle++;
        end

        // Program parks in a self jump, so nothing more may be written
        repeat (tail_cycles) begin
            step_cycle();
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
